/* Bender.yml */
package:
  name: fetch_unit

sources:
  - files:
      - source/fetch_pkg.sv
      - source/axi_read_pkg.sv
      - source/icache_array.sv
      - source/refill_engine.sv
      - source/fetch_sequencer.sv
      - source/fetch_unit.sv
  - target: test
    files:
      - testbench/axi_memory_model.sv
      - testbench/fetch_unit_assertions.sv
      - testbench/tb_fetch_unit.sv

/* project.f */
source/fetch_pkg.sv
source/axi_read_pkg.sv
source/icache_array.sv
source/refill_engine.sv
source/fetch_sequencer.sv
source/fetch_unit.sv
testbench/axi_memory_model.sv
testbench/fetch_unit_assertions.sv
testbench/tb_fetch_unit.sv

/* source/axi_read_pkg.sv */
`default_nettype none

package axi_read_pkg;

  localparam int burst_beats = 4;
  localparam logic [7:0] burst_len = 8'(burst_beats - 1);
  // 4 bytes per beat
  localparam logic [2:0] burst_size = 3'b010;
  localparam logic [1:0] burst_incr = 2'b01;

  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
  } ar_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
    logic        last;
  } r_t;

  typedef enum logic [1:0] {
    idle,
    address,
    data
  } refill_state_t;

endpackage

`default_nettype wire

/* source/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // cache geometry, 4 lines of 16 bytes
  localparam int line_words = 4;
  localparam int index_bits = 2;
  localparam int offset_bits = 4;
  localparam int tag_bits = 32 - index_bits - offset_bits;

  localparam logic [31:0] reset_pc = 32'h8000_0000;

  // word 0 sits in the low bits
  typedef logic [line_words*32-1:0] line_t;

  // one item toward decode
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic        fault;
  } fetch_out_t;

  // from later pipeline stages
  typedef struct packed {
    logic [31:0] target;
  } redirect_t;

  typedef enum logic [1:0] {
    lookup,
    wait_refill,
    faulted
  } seq_state_t;

endpackage

`default_nettype wire

/* source/fetch_sequencer.sv */
`default_nettype none
`timescale 1ns/1ns

module fetch_sequencer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   redirect_valid,
  input  fetch_pkg::redirect_t   redirect,
  output logic [31:0]            lookup_pc,
  input  logic                   hit,
  input  logic [31:0]            word,
  output logic                   refill_start,
  output logic [31:0]            refill_addr,
  input  logic                   refill_done,
  output logic                   out_valid,
  output fetch_pkg::fetch_out_t  out,
  input  logic                   out_ready
);
  import fetch_pkg::*;

  seq_state_t  state;
  logic [31:0] pc_q;
  logic        refill_pending;
  logic        slot_free;
  logic        can_lookup;
  logic        redirect_aligned;
  seq_state_t  resume_state;

  // output register is empty or drains this cycle
  assign slot_free = !out_valid || out_ready;
  assign can_lookup = (state == lookup) && slot_free && !redirect_valid;
  assign redirect_aligned = (redirect.target[1:0] == 2'b00);

  assign lookup_pc = pc_q;
  assign refill_start = can_lookup && !hit;
  assign refill_addr = {pc_q[31:offset_bits], {offset_bits{1'b0}}};

  // a burst in flight cannot be cancelled, so wait it out first
  assign resume_state = (refill_pending && !refill_done) ? wait_refill : lookup;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= lookup;
      pc_q <= reset_pc;
      out_valid <= 1'b0;
      refill_pending <= 1'b0;
    end else begin
      if (refill_start) begin
        refill_pending <= 1'b1;
      end else if (refill_done) begin
        refill_pending <= 1'b0;
      end

      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end

      if (redirect_valid) begin
        pc_q <= redirect.target;
        if (redirect_aligned) begin
          out_valid <= 1'b0;
          state <= resume_state;
        end else begin
          // single fault item, never goes to memory
          out_valid <= 1'b1;
          state <= faulted;
        end
      end else begin
        case (state)
          lookup: begin
            if (can_lookup) begin
              if (hit) begin
                out_valid <= 1'b1;
                pc_q <= pc_q + 32'd4;
              end else begin
                state <= wait_refill;
              end
            end
          end
          wait_refill: begin
            // look up again, now a hit
            if (refill_done) begin
              state <= lookup;
            end
          end
          faulted: state <= faulted;
          default: state <= lookup;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (redirect_valid && !redirect_aligned) begin
      out <= '{pc: redirect.target, inst: 32'h0, fault: 1'b1};
    end else if (can_lookup && hit) begin
      out <= '{pc: pc_q, inst: word, fault: 1'b0};
    end
  end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`default_nettype none
`timescale 1ns/1ns

module fetch_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   redirect_valid,
  input  fetch_pkg::redirect_t   redirect,
  input  logic                   flush_cache,
  output logic                   out_valid,
  output fetch_pkg::fetch_out_t  out,
  input  logic                   out_ready,
  output logic                   arvalid,
  output axi_read_pkg::ar_t      ar,
  input  logic                   arready,
  output logic                   rready,
  input  logic                   rvalid,
  input  axi_read_pkg::r_t       r
);

  logic [31:0] lookup_pc;
  logic        hit;
  logic [31:0] word;
  logic        refill_start;
  logic [31:0] refill_addr;
  logic        refill_done;
  logic        fill_valid;
  logic [31:0] fill_addr;
  logic [31:0] fill_data;
  logic        fill_last;

  fetch_sequencer u_sequencer (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect       (redirect),
    .lookup_pc      (lookup_pc),
    .hit            (hit),
    .word           (word),
    .refill_start   (refill_start),
    .refill_addr    (refill_addr),
    .refill_done    (refill_done),
    .out_valid      (out_valid),
    .out            (out),
    .out_ready      (out_ready)
  );

  icache_array u_cache (
    .clock      (clock),
    .reset      (reset),
    .lookup_pc  (lookup_pc),
    .hit        (hit),
    .word       (word),
    .flush      (flush_cache),
    .fill_valid (fill_valid),
    .fill_addr  (fill_addr),
    .fill_data  (fill_data),
    .fill_last  (fill_last)
  );

  refill_engine u_refill (
    .clock        (clock),
    .reset        (reset),
    .refill_start (refill_start),
    .refill_addr  (refill_addr),
    .refill_done  (refill_done),
    .arvalid      (arvalid),
    .ar           (ar),
    .arready      (arready),
    .rready       (rready),
    .rvalid       (rvalid),
    .r            (r),
    .fill_valid   (fill_valid),
    .fill_addr    (fill_addr),
    .fill_data    (fill_data),
    .fill_last    (fill_last)
  );

endmodule

`default_nettype wire

/* source/icache_array.sv */
`default_nettype none
`timescale 1ns/1ns

module icache_array (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] lookup_pc,
  output logic        hit,
  output logic [31:0] word,
  input  logic        flush,
  input  logic        fill_valid,
  input  logic [31:0] fill_addr,
  input  logic [31:0] fill_data,
  input  logic        fill_last
);
  import fetch_pkg::*;

  logic [2**index_bits-1:0] valid_q;
  logic [tag_bits-1:0]      tag_q [2**index_bits];
  line_t                    data_q [2**index_bits];

  logic [index_bits-1:0]    rd_index;
  logic [tag_bits-1:0]      rd_tag;
  logic [offset_bits-3:0]   rd_word;
  line_t                    rd_line;
  logic [index_bits-1:0]    wr_index;

  // pc fields: tag | index | word | byte
  assign rd_index = lookup_pc[offset_bits +: index_bits];
  assign rd_tag = lookup_pc[31 -: tag_bits];
  assign rd_word = lookup_pc[offset_bits-1:2];
  assign wr_index = fill_addr[offset_bits +: index_bits];

  assign rd_line = data_q[rd_index];
  assign hit = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
  assign word = rd_line[{rd_word, 5'b0} +: 32];

  // flush beats a fill ending in the same cycle
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      valid_q <= '0;
    end else if (fill_valid) begin
      // line is unusable until its last beat lands
      valid_q[wr_index] <= fill_last;
    end
  end

  // beats enter at the top and move down one word each
  always_ff @(posedge clock) begin
    if (fill_valid) begin
      data_q[wr_index] <= {fill_data, data_q[wr_index][$bits(line_t)-1:32]};
      if (fill_last) begin
        tag_q[wr_index] <= fill_addr[31 -: tag_bits];
      end
    end
  end

endmodule

`default_nettype wire

/* source/refill_engine.sv */
`default_nettype none
`timescale 1ns/1ns

module refill_engine (
  input  logic               clock,
  input  logic               reset,
  input  logic               refill_start,
  input  logic [31:0]        refill_addr,
  output logic               refill_done,
  output logic               arvalid,
  output axi_read_pkg::ar_t  ar,
  input  logic               arready,
  output logic               rready,
  input  logic               rvalid,
  input  axi_read_pkg::r_t   r,
  output logic               fill_valid,
  output logic [31:0]        fill_addr,
  output logic [31:0]        fill_data,
  output logic               fill_last
);
  import axi_read_pkg::*;

  refill_state_t state;
  logic [31:0]   line_addr;
  logic          beat;

  assign beat = (state == data) && rvalid && rready;

  // fixed INCR burst covering one line
  assign ar = '{addr: line_addr, len: burst_len, size: burst_size, burst: burst_incr};

  assign fill_valid = beat;
  assign fill_addr = line_addr;
  assign fill_data = r.data;
  assign fill_last = r.last;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
      arvalid <= 1'b0;
      rready <= 1'b0;
      refill_done <= 1'b0;
    end else begin
      refill_done <= 1'b0;
      case (state)
        idle: begin
          if (refill_start) begin
            arvalid <= 1'b1;
            state <= address;
          end
        end
        address: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready <= 1'b1;
            state <= data;
          end
        end
        data: begin
          // the line is written on this same edge
          if (beat && r.last) begin
            rready <= 1'b0;
            refill_done <= 1'b1;
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // starts are only taken while idle
  always_ff @(posedge clock) begin
    if (state == idle && refill_start) begin
      line_addr <= refill_addr;
    end
  end

endmodule

`default_nettype wire

/* testbench/axi_memory_model.sv */
`default_nettype none
`timescale 1ns/1ns

module axi_memory_model (
  input  logic              clock,
  input  logic              reset,
  input  logic              arvalid,
  input  axi_read_pkg::ar_t ar,
  output logic              arready,
  input  logic              rready,
  output logic              rvalid,
  output axi_read_pkg::r_t  r
);
  import axi_read_pkg::*;

  logic [31:0] beat_addr;
  int          beat_count;
  int          stall;
  logic        taken;

  // every byte address reads back as itself xor a constant
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return addr ^ 32'hdead_0000;
  endfunction

  initial begin
    arready = 1'b0;
    rvalid = 1'b0;
    r = '0;
    forever begin
      @(negedge clock);
      if (!reset && arvalid) begin
        repeat ($urandom_range(0, 3)) @(negedge clock);
        // arvalid is held, so this is taken on the next edge
        arready = 1'b1;
        beat_addr = ar.addr;
        beat_count = int'(ar.len) + 1;
        @(negedge clock);
        arready = 1'b0;
        for (int i = 0; i < beat_count; i++) begin
          repeat ($urandom_range(0, 2)) @(negedge clock);
          rvalid = 1'b1;
          r = '{data: word_at(beat_addr), resp: 2'b00, last: (i == beat_count - 1)};
          taken = rready;
          stall = 0;
          @(negedge clock);
          // give up on a beat nobody takes
          while (!taken && stall < 64) begin
            taken = rready;
            stall++;
            @(negedge clock);
          end
          rvalid = 1'b0;
          beat_addr = beat_addr + 32'd4;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/fetch_unit_assertions.sv */
`default_nettype none
`timescale 1ns/1ns

module fetch_unit_assertions (
  input logic                  clock,
  input logic                  reset,
  input logic                  redirect_valid,
  input logic                  out_valid,
  input fetch_pkg::fetch_out_t out,
  input logic                  out_ready,
  input logic                  arvalid,
  input axi_read_pkg::ar_t     ar,
  input logic                  arready,
  input logic                  rready
);

  int failures = 0;

  ar_held: assert property (@(posedge clock) disable iff (reset)
      arvalid && !arready |=> arvalid && $stable(ar))
    else begin
      failures = failures + 1;
      $error("read address channel changed before arready");
    end

  // a redirect may drop or replace the pending item
  out_held: assert property (@(posedge clock) disable iff (reset)
      out_valid && !out_ready && !redirect_valid |=> out_valid && $stable(out))
    else begin
      failures = failures + 1;
      $error("decode item changed while out_ready was low");
    end

  phases_apart: assert property (@(posedge clock) disable iff (reset)
      !(rready && arvalid))
    else begin
      failures = failures + 1;
      $error("rready high during the address phase");
    end

endmodule

bind fetch_unit fetch_unit_assertions handshake_checks (.*);

`default_nettype wire

/* testbench/tb_fetch_unit.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_fetch_unit;
  import fetch_pkg::*;
  import axi_read_pkg::*;

  localparam int item_timeout = 400;

  typedef struct packed {
    logic        jump;
    logic [31:0] target;
    logic [7:0]  count;
    logic        random_ready;
    logic [3:0]  bursts;
    logic        drain;
    logic        flush;
  } row_t;

  logic       clock;
  logic       reset;
  logic       redirect_valid;
  redirect_t  redirect;
  logic       flush_cache;
  logic       out_valid;
  fetch_out_t out;
  logic       out_ready;
  logic       arvalid;
  ar_t        ar;
  logic       arready;
  logic       rready;
  logic       rvalid;
  r_t         r;

  row_t        rows [8];
  int          bursts;
  int          burst_base;
  logic [31:0] expected_pc;

  fetch_unit DUT (.*);

  axi_memory_model memory (.*);

  always #10 clock = ~clock;

  always @(posedge clock) begin
    if (reset) begin
      bursts <= 0;
    end else if (arvalid && arready) begin
      bursts <= bursts + 1;
      // one line per burst: four INCR beats of 4 bytes from a line boundary
      check_value("ar.addr offset", 32'(ar.addr[3:0]), 32'd0);
      check_value("ar.len", 32'(ar.len), 32'd3);
      check_value("ar.size", 32'(ar.size), 32'd2);
      check_value("ar.burst", 32'(ar.burst), 32'd1);
    end
  end

  always @(negedge clock) begin
    if (DUT.handshake_checks.failures != 0) begin
      abort_run("a handshake assertion failed");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("error at %0t: %s", $time, why);
    $display("RESULT: FAIL");
    $fatal(1, why);
  endtask

  function automatic logic [31:0] memory_word(input logic [31:0] addr);
    return addr ^ 32'hdead_0000;
  endfunction

  task automatic wait_refill_idle();
    int waited;
    waited = 0;
    while (arvalid || rready) begin
      @(negedge clock);
      waited++;
      if (waited > item_timeout) begin
        abort_run("refill engine never went idle");
      end
    end
  endtask

  // ready is driven first, so a seen handshake completes on the next edge
  task automatic accept_items(input row_t row, input logic fault);
    int accepted;
    int waited;
    accepted = 0;
    waited = 0;
    while (accepted < int'(row.count)) begin
      @(negedge clock);
      out_ready = row.random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
      if (out_valid && out_ready) begin
        check_value("out.fault", 32'(out.fault), 32'(fault));
        if (fault) begin
          check_value("out.pc", out.pc, row.target);
        end else begin
          check_value("out.pc", out.pc, expected_pc);
          check_value("out.inst", out.inst, memory_word(expected_pc));
          expected_pc = expected_pc + 32'd4;
        end
        accepted++;
        waited = 0;
      end else begin
        waited++;
        if (waited > item_timeout) begin
          abort_run("no item reached decode before the timeout");
        end
      end
    end
  endtask

  task automatic apply_row(input row_t row);
    logic fault;
    fault = row.jump && (row.target[1:0] != 2'b00);
    if (row.drain) begin
      wait_refill_idle();
    end
    burst_base = bursts;
    if (row.jump) begin
      redirect_valid = 1'b1;
      redirect = '{target: row.target};
      flush_cache = row.flush;
      expected_pc = row.target;
      @(negedge clock);
      redirect_valid = 1'b0;
      flush_cache = 1'b0;
    end
    accept_items(row, fault);
    if (fault) begin
      // nothing may follow a fault item
      repeat (16) begin
        @(negedge clock);
        out_ready = 1'b1;
        check_value("out_valid", 32'(out_valid), 32'd0);
      end
    end
    @(negedge clock);
    out_ready = 1'b0;
    check_value("ar bursts", 32'(bursts - burst_base), 32'(row.bursts));
  endtask

  initial begin
    void'($urandom(32'h3370_d683));
    clock = 1'b0;
    reset = 1'b1;
    redirect_valid = 1'b0;
    redirect = '0;
    flush_cache = 1'b0;
    out_ready = 1'b0;

    // jump, target, items, random ready, bursts, drain first, flush
    rows[0] = '{1'b0, reset_pc, 8'd8, 1'b0, 4'd2, 1'b1, 1'b0};
    rows[1] = '{1'b1, 32'h8000_0000, 8'd8, 1'b0, 4'd0, 1'b1, 1'b0};
    rows[2] = '{1'b1, 32'h8000_0040, 8'd8, 1'b0, 4'd2, 1'b1, 1'b0};
    rows[3] = '{1'b1, 32'h8000_0000, 8'd12, 1'b1, 4'd3, 1'b1, 1'b0};
    // lands while the line at 0x30 is still refilling
    rows[4] = '{1'b1, 32'h8000_0040, 8'd4, 1'b1, 4'd2, 1'b0, 1'b0};
    // lines at 0x40 and 0x50 are cached before the flush
    rows[5] = '{1'b1, 32'h8000_0040, 8'd8, 1'b0, 4'd2, 1'b1, 1'b1};
    rows[6] = '{1'b1, 32'h8000_0006, 8'd1, 1'b0, 4'd0, 1'b1, 1'b0};
    rows[7] = '{1'b1, 32'h8000_0050, 8'd4, 1'b0, 4'd0, 1'b1, 1'b0};

    repeat (10) @(negedge clock);
    reset = 1'b0;
    expected_pc = reset_pc;

    foreach (rows[i]) begin
      apply_row(rows[i]);
    end

    if (DUT.handshake_checks.failures == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
